//--- include/input_pipe_config.svh
`ifndef INPUT_PIPE_CONFIG_SVH
`define INPUT_PIPE_CONFIG_SVH

// output window width in words
`define UNITS 3

`define WORD_WIDTH 8

// tallest supported kernel, odd so the rows centre on the middle of a strip
`define KERNEL_H_MAX 3

// words per input beat, a power of two that covers UNITS_EDGES
`define S_WORDS 8

`define UNITS_EDGES (`UNITS + `KERNEL_H_MAX - 1)

`endif

//--- rtl/input_pipe_pkg.sv
`include "input_pipe_config.svh"

package input_pipe_pkg;

  localparam int KH_BITS = $clog2(`KERNEL_H_MAX);

  // header beat layout, as word indices into the data field
  localparam int I_IS_MAXPOOL = 0; // flag sits in bit 0 of this word
  localparam int I_KERNEL_H_1 = 1; // kernel height minus one in the low bits

  typedef logic [`WORD_WIDTH-1:0] word_t;

  typedef struct packed {
    word_t [`S_WORDS-1:0] data;
    logic [`S_WORDS-1:0]  keep;
    logic                 last;
  } in_beat_t;

  typedef struct packed {
    logic               is_maxpool;
    logic [KH_BITS-1:0] kernel_h_1;
  } header_t;

  typedef struct packed {
    word_t [`UNITS-1:0] words;
    logic               last;
  } win_t;

  // a window travels with the header of the packet it came from
  typedef struct packed {
    win_t    win;
    header_t header;
  } shift_out_t;

  typedef struct packed {
    word_t [`UNITS-1:0] pixels_1;
    word_t [`UNITS-1:0] pixels_2;
    logic               is_maxpool;
    logic               last;
  } out_beat_t;

endpackage

//--- rtl/axis_skid_buffer.sv
module axis_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     aclk,
  input  logic     reset,
  input  payload_t s_data,
  input  logic     s_valid,
  output logic     s_ready,
  output payload_t m_data,
  output logic     m_valid,
  input  logic     m_ready
);

  payload_t main_q;
  payload_t skid_q;
  logic     main_valid;
  logic     skid_valid;
  logic     load_main;

  assign load_main = m_ready || !main_valid; // main register drains or is empty this cycle
  assign s_ready   = !skid_valid;            // straight from a flop, no path from m_ready
  assign m_data    = main_q;
  assign m_valid   = main_valid;

  always_ff @(posedge aclk) begin
    if (reset) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (load_main) begin
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= s_valid;
      end
    end else if (s_valid && !skid_valid) begin
      skid_valid <= 1'b1; // downstream stalled after ready was already seen high
    end
  end

  always_ff @(posedge aclk) begin
    if (load_main) begin
      main_q <= skid_valid ? skid_q : s_data;
    end else if (s_valid && !skid_valid) begin
      skid_q <= s_data;
    end
  end

endmodule

//--- rtl/column_shifter.sv
`include "input_pipe_config.svh"

module column_shifter (
  input  logic                       aclk,
  input  logic                       reset,
  input  input_pipe_pkg::in_beat_t   s_beat,
  input  logic                       s_valid,
  output logic                       s_ready,
  output input_pipe_pkg::shift_out_t m_out,
  output logic                       m_valid,
  input  logic                       m_ready
);
  import input_pipe_pkg::*;

  logic                     expect_hdr;
  header_t                  hdr_q;
  word_t [`UNITS_EDGES-1:0] data_q;
  logic                     last_q;
  logic [KH_BITS-1:0]       off_q;
  logic                     valid_q;
  logic [KH_BITS-1:0]       first_off;
  logic [KH_BITS-1:0]       last_off;
  logic                     at_last;
  logic                     accept;
  logic                     take_data;

  // rows of the kernel are centred in the strip, so height 1 uses offset 1 only
  assign first_off = KH_BITS'((`KERNEL_H_MAX - 1 - int'(hdr_q.kernel_h_1)) / 2);
  assign last_off  = first_off + hdr_q.kernel_h_1;
  assign at_last   = (off_q == last_off);

  // a new beat enters only once the final window of the current one leaves
  assign s_ready   = !valid_q || (m_ready && at_last);
  assign accept    = s_valid && s_ready;
  assign take_data = accept && !expect_hdr;

  always_ff @(posedge aclk) begin
    if (reset) begin
      expect_hdr <= 1'b1;
      hdr_q      <= '0;
      off_q      <= '0;
      valid_q    <= 1'b0;
    end else begin
      if (accept && expect_hdr) begin
        expect_hdr       <= 1'b0;
        hdr_q.is_maxpool <= s_beat.data[I_IS_MAXPOOL][0];
        hdr_q.kernel_h_1 <= s_beat.data[I_KERNEL_H_1][KH_BITS-1:0];
      end
      if (take_data) begin
        off_q   <= first_off;
        valid_q <= 1'b1;
        if (s_beat.last) begin
          expect_hdr <= 1'b1; // following beat opens the next packet
        end
      end else if (valid_q && m_ready) begin
        if (at_last) begin
          valid_q <= 1'b0;
        end else begin
          off_q <= off_q + KH_BITS'(1);
        end
      end
    end
  end

  // only the significant words are held, and unkept ones read as zero padding
  always_ff @(posedge aclk) begin
    if (take_data) begin
      last_q <= s_beat.last;
      for (int i = 0; i < `UNITS_EDGES; i++) begin
        data_q[i] <= s_beat.keep[i] ? s_beat.data[i] : '0;
      end
    end
  end

  always_comb begin
    for (int j = 0; j < `UNITS; j++) begin
      m_out.win.words[j] = data_q[int'(off_q) + j];
    end
    m_out.win.last = last_q && at_last; // only the final row offset closes the packet
    m_out.header   = hdr_q;
  end

  assign m_valid = valid_q;

endmodule

//--- rtl/stream_join.sv
module stream_join (
  input  logic                       aclk,
  input  logic                       reset,
  input  input_pipe_pkg::shift_out_t a_out,
  input  input_pipe_pkg::shift_out_t b_out,
  input  logic                       a_valid,
  input  logic                       b_valid,
  output logic                       a_ready,
  output logic                       b_ready,
  output input_pipe_pkg::out_beat_t  m_beat,
  output logic                       m_valid,
  input  logic                       m_ready,
  output logic                       config_error
);

  logic both_valid;
  logic fire;
  logic kh_mismatch;
  logic last_mismatch;

  assign both_valid = a_valid && b_valid;
  assign fire       = both_valid && m_ready;

  // neither side advances alone, which keeps the two shifters in lockstep
  assign a_ready = fire;
  assign b_ready = fire;
  assign m_valid = both_valid;

  assign m_beat.pixels_1   = a_out.win.words;
  assign m_beat.pixels_2   = b_out.win.words;
  assign m_beat.is_maxpool = a_out.header.is_maxpool; // stream 1 owns the pooling flag
  assign m_beat.last       = a_out.win.last;

  assign kh_mismatch   = (a_out.header.kernel_h_1 != b_out.header.kernel_h_1);
  assign last_mismatch = (a_out.win.last != b_out.win.last);

  always_ff @(posedge aclk) begin
    if (reset) begin
      config_error <= 1'b0;
    end else if (fire && (kh_mismatch || last_mismatch)) begin
      config_error <= 1'b1; // held until the next reset
    end
  end

endmodule

//--- rtl/axis_input_pipe.sv
module axis_input_pipe (
  input  logic                      aclk,
  input  logic                      reset,
  input  input_pipe_pkg::in_beat_t  s_axis_pixels_1,
  input  logic                      s_axis_pixels_1_tvalid,
  output logic                      s_axis_pixels_1_tready,
  input  input_pipe_pkg::in_beat_t  s_axis_pixels_2,
  input  logic                      s_axis_pixels_2_tvalid,
  output logic                      s_axis_pixels_2_tready,
  output input_pipe_pkg::out_beat_t m_axis,
  output logic                      m_axis_tvalid,
  input  logic                      m_axis_tready,
  output logic                      config_error
);
  import input_pipe_pkg::*;

  in_beat_t   in_1_beat;
  logic       in_1_valid;
  logic       in_1_ready;
  in_beat_t   in_2_beat;
  logic       in_2_valid;
  logic       in_2_ready;
  shift_out_t sh_1_out;
  logic       sh_1_valid;
  logic       sh_1_ready;
  shift_out_t sh_2_out;
  logic       sh_2_valid;
  logic       sh_2_ready;
  out_beat_t  join_beat;
  logic       join_valid;
  logic       join_ready;

  axis_skid_buffer #(.payload_t(in_beat_t)) in_1 (
    .aclk, .reset,
    .s_data (s_axis_pixels_1), .s_valid (s_axis_pixels_1_tvalid),
    .s_ready (s_axis_pixels_1_tready),
    .m_data (in_1_beat), .m_valid (in_1_valid), .m_ready (in_1_ready)
  );

  axis_skid_buffer #(.payload_t(in_beat_t)) in_2 (
    .aclk, .reset,
    .s_data (s_axis_pixels_2), .s_valid (s_axis_pixels_2_tvalid),
    .s_ready (s_axis_pixels_2_tready),
    .m_data (in_2_beat), .m_valid (in_2_valid), .m_ready (in_2_ready)
  );

  column_shifter shift_1 (
    .aclk, .reset,
    .s_beat (in_1_beat), .s_valid (in_1_valid), .s_ready (in_1_ready),
    .m_out (sh_1_out), .m_valid (sh_1_valid), .m_ready (sh_1_ready)
  );

  column_shifter shift_2 (
    .aclk, .reset,
    .s_beat (in_2_beat), .s_valid (in_2_valid), .s_ready (in_2_ready),
    .m_out (sh_2_out), .m_valid (sh_2_valid), .m_ready (sh_2_ready)
  );

  // join is a reserved word, so the instance carries a suffix
  stream_join join_inst (
    .aclk, .reset,
    .a_out (sh_1_out), .b_out (sh_2_out),
    .a_valid (sh_1_valid), .b_valid (sh_2_valid),
    .a_ready (sh_1_ready), .b_ready (sh_2_ready),
    .m_beat (join_beat), .m_valid (join_valid), .m_ready (join_ready),
    .config_error (config_error)
  );

  axis_skid_buffer #(.payload_t(out_beat_t)) out_buf (
    .aclk, .reset,
    .s_data (join_beat), .s_valid (join_valid), .s_ready (join_ready),
    .m_data (m_axis), .m_valid (m_axis_tvalid), .m_ready (m_axis_tready)
  );

endmodule

//--- tests/axis_input_pipe_props.sv
module axis_input_pipe_props (
  input logic                      aclk,
  input logic                      reset,
  input input_pipe_pkg::in_beat_t  s_axis_pixels_1,
  input logic                      s_axis_pixels_1_tvalid,
  input logic                      s_axis_pixels_1_tready,
  input input_pipe_pkg::in_beat_t  s_axis_pixels_2,
  input logic                      s_axis_pixels_2_tvalid,
  input logic                      s_axis_pixels_2_tready,
  input input_pipe_pkg::out_beat_t m_axis,
  input logic                      m_axis_tvalid,
  input logic                      m_axis_tready,
  input logic                      config_error
);
  timeunit 1ns;
  timeprecision 100ps;

  in_1_hold: assert property (@(posedge aclk) disable iff (reset)
    s_axis_pixels_1_tvalid && !s_axis_pixels_1_tready |=> s_axis_pixels_1_tvalid)
    else $error("stream 1 valid dropped before its transfer");
  in_1_stable: assert property (@(posedge aclk) disable iff (reset)
    s_axis_pixels_1_tvalid && !s_axis_pixels_1_tready |=> $stable(s_axis_pixels_1))
    else $error("stream 1 payload changed while stalled");
  in_2_hold: assert property (@(posedge aclk) disable iff (reset)
    s_axis_pixels_2_tvalid && !s_axis_pixels_2_tready |=> s_axis_pixels_2_tvalid)
    else $error("stream 2 valid dropped before its transfer");
  in_2_stable: assert property (@(posedge aclk) disable iff (reset)
    s_axis_pixels_2_tvalid && !s_axis_pixels_2_tready |=> $stable(s_axis_pixels_2))
    else $error("stream 2 payload changed while stalled");
  out_hold: assert property (@(posedge aclk) disable iff (reset)
    m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid)
    else $error("output valid dropped before its transfer");
  out_stable: assert property (@(posedge aclk) disable iff (reset)
    m_axis_tvalid && !m_axis_tready |=> $stable(m_axis))
    else $error("output payload changed while stalled");
  error_sticky: assert property (@(posedge aclk) disable iff (reset)
    config_error |=> config_error)
    else $error("config_error fell without a reset");

endmodule

bind axis_input_pipe axis_input_pipe_props props (
  .aclk (aclk), .reset (reset),
  .s_axis_pixels_1 (s_axis_pixels_1), .s_axis_pixels_1_tvalid (s_axis_pixels_1_tvalid),
  .s_axis_pixels_1_tready (s_axis_pixels_1_tready),
  .s_axis_pixels_2 (s_axis_pixels_2), .s_axis_pixels_2_tvalid (s_axis_pixels_2_tvalid),
  .s_axis_pixels_2_tready (s_axis_pixels_2_tready),
  .m_axis (m_axis), .m_axis_tvalid (m_axis_tvalid), .m_axis_tready (m_axis_tready),
  .config_error (config_error)
);

//--- tests/axis_input_pipe_tb.sv
`include "input_pipe_config.svh"

module axis_input_pipe_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import input_pipe_pkg::*;

  typedef struct packed {
    int                  kh_1;      // kernel height on stream 1
    int                  kh_2;
    logic                is_maxpool;
    int                  beats_1;   // data beats after the header
    int                  beats_2;
    logic [`S_WORDS-1:0] keep;
    logic                gaps;      // random input gaps and output stalls
    logic                restart;   // reset the DUT ahead of this packet
    logic                exp_err;
  } row_t;

  localparam int N_ROWS = 8;

  logic       aclk;
  logic       reset;
  in_beat_t   s_axis_pixels_1;
  logic       s_axis_pixels_1_tvalid;
  logic       s_axis_pixels_1_tready;
  in_beat_t   s_axis_pixels_2;
  logic       s_axis_pixels_2_tvalid;
  logic       s_axis_pixels_2_tready;
  out_beat_t  m_axis;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  logic       config_error;

  row_t       rows [N_ROWS];
  in_beat_t   beats_1 [$];
  in_beat_t   beats_2 [$];
  shift_out_t model_1 [$];
  shift_out_t model_2 [$];
  logic [31:0] lfsr_q = 32'h61d3;
  logic       stall_out = 1'b0;
  int         total_1 = 0;
  int         total_2 = 0;
  int         out_count = 0;
  int         cycles = 0;
  int         limit = 0;

  axis_input_pipe dut (.*);

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic take_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    return b;
  endfunction

  function automatic word_t take_word();
    word_t w;
    w = '0;
    for (int i = 0; i < `WORD_WIDTH; i++) begin
      w = {w[`WORD_WIDTH-2:0], take_bit()};
    end
    return w;
  endfunction

  function automatic int table_beats();
    int sum;
    sum = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      sum = sum + rows[r].beats_1 + rows[r].beats_2 + 2; // headers count too
    end
    return sum;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_value(input string name, input logic [63:0] got, input logic [63:0] want);
    abort_run($sformatf("error at %0d ns: %s is 'h%0h, expected 'h%0h", $time, name, got, want));
  endtask

  task automatic compare_beat(input win_t want_1, input win_t want_2, input logic want_mp,
                              input out_beat_t got);
    if (got.pixels_1 !== want_1.words) begin
      report_value("m_axis.pixels_1", 64'(got.pixels_1), 64'(want_1.words));
    end else if (got.pixels_2 !== want_2.words) begin
      report_value("m_axis.pixels_2", 64'(got.pixels_2), 64'(want_2.words));
    end else if (got.is_maxpool !== want_mp) begin
      report_value("m_axis.is_maxpool", 64'(got.is_maxpool), 64'(want_mp));
    end else if (got.last !== want_1.last) begin
      report_value("m_axis.last", 64'(got.last), 64'(want_1.last));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic want);
    if (got !== want) begin
      report_value(name, 64'(got), 64'(want));
    end
  endtask

  task automatic apply_reset();
    reset = 1'b1;
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    reset = 1'b0;
  endtask

  task automatic push_beat(input bit second, input in_beat_t beat);
    if (second) begin
      beats_2.push_back(beat);
    end else begin
      beats_1.push_back(beat);
    end
  endtask

  task automatic push_window(input bit second, input shift_out_t win);
    if (second) begin
      model_2.push_back(win);
      total_2++;
    end else begin
      model_1.push_back(win);
      total_1++;
    end
  endtask

  // one packet per stream, with the windows each data beat should expand into
  task automatic build_packet(input bit second, input row_t row);
    in_beat_t   beat;
    shift_out_t win;
    word_t      pad [`S_WORDS];
    int         kh;
    int         n;
    int         first;
    kh    = second ? row.kh_2 : row.kh_1;
    n     = second ? row.beats_2 : row.beats_1;
    first = (kh == 1) ? 1 : 0; // height 1 takes the middle row only
    beat  = '0;
    beat.data[I_IS_MAXPOOL] = word_t'(row.is_maxpool);
    beat.data[I_KERNEL_H_1] = word_t'(kh - 1);
    beat.keep = '1;
    push_beat(second, beat);
    for (int b = 0; b < n; b++) begin
      for (int i = 0; i < `S_WORDS; i++) begin
        beat.data[i] = take_word();
        pad[i]       = row.keep[i] ? beat.data[i] : '0;
      end
      beat.keep = row.keep;
      beat.last = (b == n - 1);
      push_beat(second, beat);
      for (int off = first; off < first + kh; off++) begin
        for (int j = 0; j < `UNITS; j++) begin
          win.win.words[j] = pad[off + j];
        end
        win.win.last          = beat.last && (off == first + kh - 1);
        win.header.is_maxpool = row.is_maxpool;
        win.header.kernel_h_1 = KH_BITS'(kh - 1);
        push_window(second, win);
      end
    end
  endtask

  task automatic drive_input(input bit second, input in_beat_t beat, input logic valid);
    if (second) begin
      s_axis_pixels_2        = beat;
      s_axis_pixels_2_tvalid = valid;
    end else begin
      s_axis_pixels_1        = beat;
      s_axis_pixels_1_tvalid = valid;
    end
  endtask

  task automatic send_stream(input bit second, input logic gaps);
    in_beat_t beat;
    int       left;
    logic     holding;
    logic     ready;
    left    = second ? beats_2.size() : beats_1.size();
    holding = 1'b0;
    while (left > 0) begin
      @(negedge aclk);
      ready = second ? s_axis_pixels_2_tready : s_axis_pixels_1_tready; // a flop, stable here
      if (!holding && gaps && take_bit()) begin
        drive_input(second, '0, 1'b0);
      end else begin
        beat = second ? beats_2[0] : beats_1[0];
        drive_input(second, beat, 1'b1);
        holding = !ready;
        if (ready) begin
          if (second) begin
            void'(beats_2.pop_front());
          end else begin
            void'(beats_1.pop_front());
          end
          left--;
        end
      end
    end
    @(negedge aclk);
    drive_input(second, '0, 1'b0);
  endtask

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  initial begin
    m_axis_tready = 1'b1;
    forever begin
      @(negedge aclk);
      m_axis_tready = stall_out ? take_bit() : 1'b1;
    end
  end

  initial begin
    shift_out_t want_1;
    shift_out_t want_2;
    forever begin
      @(posedge aclk);
      if (!reset && m_axis_tvalid && m_axis_tready) begin
        if (model_1.size() == 0 || model_2.size() == 0) begin
          abort_run("an output beat appeared with no window left in the model");
        end else begin
          want_1 = model_1.pop_front();
          want_2 = model_2.pop_front();
          compare_beat(want_1.win, want_2.win, want_1.header.is_maxpool, m_axis);
          out_count++;
        end
      end
    end
  end

  initial begin
    forever begin
      @(posedge aclk);
      cycles++;
      if (limit > 0 && cycles > limit) begin
        abort_run($sformatf("timeout: the run did not finish within %0d cycles", limit));
      end
    end
  end

  initial begin
    int target;
    reset                  = 1'b1;
    s_axis_pixels_1        = '0;
    s_axis_pixels_1_tvalid = 1'b0;
    s_axis_pixels_2        = '0;
    s_axis_pixels_2_tvalid = 1'b0;
    // kh_1 kh_2 maxpool beats_1 beats_2 keep gaps restart exp_err
    rows = '{
      '{3, 3, 1'b1, 2, 2, 8'hff, 1'b0, 1'b0, 1'b0},
      '{1, 1, 1'b0, 3, 3, 8'h1b, 1'b0, 1'b0, 1'b0},
      '{3, 3, 1'b0, 4, 4, 8'hee, 1'b1, 1'b0, 1'b0},
      '{1, 1, 1'b1, 3, 3, 8'hff, 1'b1, 1'b0, 1'b0},
      '{1, 1, 1'b0, 5, 4, 8'hff, 1'b0, 1'b0, 1'b1},  // tlasts no longer line up
      '{1, 1, 1'b0, 4, 5, 8'hf6, 1'b1, 1'b0, 1'b1},  // brings the window totals level again
      '{3, 1, 1'b1, 1, 3, 8'hff, 1'b0, 1'b1, 1'b1},  // heights differ, window counts still match
      '{3, 3, 1'b1, 2, 2, 8'hff, 1'b1, 1'b0, 1'b1}
    };
    limit = 4 * table_beats() * `KERNEL_H_MAX + 200;
    apply_reset();
    repeat (4) begin
      @(negedge aclk);
      check_flag("m_axis_tvalid", m_axis_tvalid, 1'b0);
      check_flag("config_error", config_error, 1'b0);
    end
    for (int r = 0; r < N_ROWS; r++) begin
      if (rows[r].restart) begin
        apply_reset();
        check_flag("config_error", config_error, 1'b0);
      end
      stall_out = rows[r].gaps;
      build_packet(1'b0, rows[r]);
      build_packet(1'b1, rows[r]);
      fork
        send_stream(1'b0, rows[r].gaps);
        send_stream(1'b1, rows[r].gaps);
      join
      target = (total_1 < total_2) ? total_1 : total_2; // a window with no partner waits
      while (out_count < target) begin
        @(posedge aclk);
      end
      @(negedge aclk);
      check_flag("config_error", config_error, rows[r].exp_err);
    end
    if (model_1.size() != 0 || model_2.size() != 0) begin
      abort_run("expected windows were still queued when the stimulus ran out");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+include
rtl/input_pipe_pkg.sv
rtl/axis_skid_buffer.sv
rtl/column_shifter.sv
rtl/stream_join.sv
rtl/axis_input_pipe.sv
tests/axis_input_pipe_props.sv
tests/axis_input_pipe_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the input pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=axis_input_pipe_sim

verilator --binary --timing --assert \
  -f verilog.f \
  --top-module axis_input_pipe_tb \
  --Mdir obj_dir \
  -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides the result
if grep -qF "*** TEST PASSED ***" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1
